//--- logic/soc_reg_pkg.sv
package soc_reg_pkg;

    localparam int DATA_W        = 32;
    localparam int GPIO_W        = 8;
    localparam int IRQ_W         = 8;
    localparam int IRQ_PULSE_BIT = 0;  // Latched source, all others are levels
    localparam int REG_OFF_W     = 16;

    // Config block
    localparam logic [REG_OFF_W-1:0] CONF_SCRATCH0    = 16'h0000;
    localparam logic [REG_OFF_W-1:0] CONF_SCRATCH1    = 16'h0004;
    localparam logic [REG_OFF_W-1:0] CONF_CFG_TO_CTRL = 16'h0008;
    localparam logic [REG_OFF_W-1:0] CONF_CTRL_TO_CFG = 16'h000c; // Read only
    localparam logic [REG_OFF_W-1:0] CONF_GPIO_OUT    = 16'h0010;
    localparam logic [REG_OFF_W-1:0] CONF_GPIO_OE     = 16'h0014;
    localparam logic [REG_OFF_W-1:0] CONF_GPIO_IN     = 16'h0018; // Read only

    // Interrupt controller
    localparam logic [REG_OFF_W-1:0] INTC_STATUS = 16'h0000;
    localparam logic [REG_OFF_W-1:0] INTC_MASK   = 16'h0004;
    localparam logic [REG_OFF_W-1:0] INTC_ACK    = 16'h0008;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } resp_e;

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

endpackage

//--- logic/soc_map_pkg.sv
package soc_map_pkg;
    import soc_reg_pkg::*;

    localparam int ADDR_W = 32;
    localparam int SLOT_W = 4;

    // Top-level regions behind the CPU port
    typedef enum logic [1:0] {
        REGION_MEM  = 2'd0,
        REGION_BOOT = 2'd1, // Boot ROM / SPI flash window
        REGION_LITE = 2'd2
    } region_e;

    // Slots served inside the lite region
    localparam logic [SLOT_W-1:0] SLOT_CONF = 4'h4;
    localparam logic [SLOT_W-1:0] SLOT_INTC = 4'h6;

    typedef struct packed {
        logic [3:0]  top;   // 256MB granule
        logic [7:0]  area;
        logic [19:0] low;
    } area_view_t;

    typedef struct packed {
        logic [11:0]          high;
        logic [SLOT_W-1:0]    slot;   // Peripheral select, 64KB each
        logic [REG_OFF_W-1:0] offset;
    } slot_view_t;

    // Same address word, region view and peripheral view
    typedef union packed {
        area_view_t area_v;
        slot_view_t slot_v;
    } addr_view_u;

    typedef struct packed {
        region_e              region;
        logic [SLOT_W-1:0]    slot;
        logic [REG_OFF_W-1:0] offset;
        logic                 we;
        logic [DATA_W-1:0]    wdata;
        logic [ADDR_W-1:0]    addr;
    } decoded_req_t;

endpackage

//--- logic/periph_addr_decoder.sv
module periph_addr_decoder
    import soc_map_pkg::*;
    import soc_reg_pkg::*;
(
    input  logic              req_valid_i,
    input  logic              req_we_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [DATA_W-1:0] req_wdata_i,
    output logic              dec_valid_o,
    output decoded_req_t      dec_req_o
);

    addr_view_u           view;
    region_e              region;
    logic                 is_boot;
    logic [SLOT_W-1:0]    slot;
    logic [REG_OFF_W-1:0] offset;

    assign view = req_addr_i;

    // 0x1c0xxxxx or 0x1d00xxxx
    assign is_boot = ({view.area_v.top, view.area_v.area} == 12'h1c0) ||
                     ({view.slot_v.high, view.slot_v.slot} == 16'h1d00);

    always_comb begin
        if (view.area_v.top == 4'h0) begin
            region = REGION_MEM;
        end else if (is_boot) begin
            region = REGION_BOOT;
        end else begin
            // Holes in the map also land here and get DECERR later
            region = REGION_LITE;
        end
    end

    always_comb begin
        slot   = '0;
        offset = '0;
        if (region == REGION_LITE) begin
            slot   = view.slot_v.slot;
            offset = view.slot_v.offset;
        end
    end

    assign dec_valid_o = req_valid_i;

    always_comb begin
        dec_req_o        = '0;
        dec_req_o.region = region;
        dec_req_o.slot   = slot;
        dec_req_o.offset = offset;
        dec_req_o.we     = req_we_i;
        dec_req_o.wdata  = req_wdata_i;
        dec_req_o.addr   = req_addr_i;
    end

endmodule

//--- logic/request_fifo.sv
module request_fifo
    import soc_map_pkg::*;
    import soc_reg_pkg::*;
(
    input  logic         soc_clk,
    input  logic         rst_n_i,
    input  logic         push_i,
    input  decoded_req_t push_data_i,
    input  logic         pop_i,
    output logic         valid_o,
    output decoded_req_t head_o,
    output logic         busy_o
);

    decoded_req_t          mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_PTR_W:0]   count_q;

    always_ff @(posedge soc_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1; // Wraps, depth is a power of two
            if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge soc_clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    assign valid_o = (count_q != '0);
    assign head_o  = mem[rd_ptr_q];
    assign busy_o  = (count_q == (FIFO_PTR_W + 1)'(FIFO_DEPTH));

    // Requester honours busy_o
    a_no_push_full: assert property (
        @(posedge soc_clk) disable iff (!rst_n_i) push_i |-> !busy_o
    ) else $error("request_fifo: push while full");

    a_no_pop_empty: assert property (
        @(posedge soc_clk) disable iff (!rst_n_i) pop_i |-> valid_o
    ) else $error("request_fifo: pop while empty");

endmodule

//--- logic/confreg_regs.sv
module confreg_regs
    import soc_reg_pkg::*;
(
    input  logic                 soc_clk,
    input  logic                 rst_n_i,
    input  logic                 wr_i,
    input  logic [REG_OFF_W-1:0] rd_offset_i,
    input  logic [REG_OFF_W-1:0] wr_offset_i,
    input  logic [DATA_W-1:0]    wdata_i,
    input  logic [GPIO_W-1:0]    gpio_i,
    input  logic [DATA_W-1:0]    dat_ctrl_to_cfg_i,
    output logic [DATA_W-1:0]    rdata_o,
    output logic [GPIO_W-1:0]    gpio_o,
    output logic [GPIO_W-1:0]    gpio_t_o,
    output logic [DATA_W-1:0]    dat_cfg_to_ctrl_o
);

    logic [DATA_W-1:0] scratch0_q;
    logic [DATA_W-1:0] scratch1_q;
    logic [DATA_W-1:0] cfg_to_ctrl_q;
    logic [GPIO_W-1:0] gpio_out_q;
    logic [GPIO_W-1:0] gpio_oe_q;

    always_ff @(posedge soc_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            scratch0_q    <= '0;
            scratch1_q    <= '0;
            cfg_to_ctrl_q <= '0;
            gpio_out_q    <= '0;
            gpio_oe_q     <= '0;
        end else if (wr_i) begin
            case (wr_offset_i)
                CONF_SCRATCH0:    scratch0_q    <= wdata_i;
                CONF_SCRATCH1:    scratch1_q    <= wdata_i;
                CONF_CFG_TO_CTRL: cfg_to_ctrl_q <= wdata_i;
                CONF_GPIO_OUT:    gpio_out_q    <= wdata_i[GPIO_W-1:0];
                CONF_GPIO_OE:     gpio_oe_q     <= wdata_i[GPIO_W-1:0];
                default: ; // Read-only and unmapped offsets ignore writes
            endcase
        end
    end

    always_comb begin
        case (rd_offset_i)
            CONF_SCRATCH0:    rdata_o = scratch0_q;
            CONF_SCRATCH1:    rdata_o = scratch1_q;
            CONF_CFG_TO_CTRL: rdata_o = cfg_to_ctrl_q;
            CONF_CTRL_TO_CFG: rdata_o = dat_ctrl_to_cfg_i;
            CONF_GPIO_OUT:    rdata_o = DATA_W'(gpio_out_q);
            CONF_GPIO_OE:     rdata_o = DATA_W'(gpio_oe_q);
            CONF_GPIO_IN:     rdata_o = DATA_W'(gpio_i);
            default:          rdata_o = '0;
        endcase
    end

    assign gpio_o            = gpio_out_q;
    assign gpio_t_o          = gpio_oe_q; // Per-pin enable
    assign dat_cfg_to_ctrl_o = cfg_to_ctrl_q;

endmodule

//--- logic/irq_controller.sv
module irq_controller
    import soc_reg_pkg::*;
(
    input  logic                 soc_clk,
    input  logic                 rst_n_i,
    input  logic [IRQ_W-1:0]     irq_i,
    input  logic                 wr_i,
    input  logic [REG_OFF_W-1:0] wr_offset_i,
    input  logic [REG_OFF_W-1:0] rd_offset_i,
    input  logic [DATA_W-1:0]    wdata_i,
    output logic [DATA_W-1:0]    rdata_o,
    output logic                 cpu_irq_o
);

    logic             pulse_q;
    logic             ack;
    logic [IRQ_W-1:0] mask_q;
    logic [IRQ_W-1:0] pending;

    assign ack = wr_i && (wr_offset_i == INTC_ACK) && wdata_i[IRQ_PULSE_BIT];

    // Sticky latch for the pulse source
    always_ff @(posedge soc_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pulse_q <= 1'b0;
        end else if (irq_i[IRQ_PULSE_BIT]) begin
            pulse_q <= 1'b1; // New pulse beats a same-cycle ack
        end else if (ack) begin
            pulse_q <= 1'b0;
        end
    end

    always_comb begin
        pending                = irq_i;
        pending[IRQ_PULSE_BIT] = pulse_q;
    end

    always_ff @(posedge soc_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mask_q    <= '0;
            cpu_irq_o <= 1'b0;
        end else begin
            if (wr_i && wr_offset_i == INTC_MASK) begin
                mask_q <= wdata_i[IRQ_W-1:0];
            end
            cpu_irq_o <= |(pending & mask_q);
        end
    end

    always_comb begin
        case (rd_offset_i)
            INTC_STATUS: rdata_o = DATA_W'(pending);
            INTC_MASK:   rdata_o = DATA_W'(mask_q);
            default:     rdata_o = '0;
        endcase
    end

endmodule

//--- logic/periph_access_unit.sv
module periph_access_unit
    import soc_map_pkg::*;
    import soc_reg_pkg::*;
(
    input  logic              soc_clk,
    input  logic              rst_n_i,
    input  logic              valid_i,
    input  decoded_req_t      head_i,
    input  logic [GPIO_W-1:0] gpio_i,
    input  logic [DATA_W-1:0] dat_ctrl_to_cfg_i,
    input  logic [IRQ_W-1:0]  irq_i,
    output logic              pop_o,
    output logic              rsp_valid_o,
    output logic [DATA_W-1:0] rsp_rdata_o,
    output resp_e             rsp_resp_o,
    output logic              fwd_valid_o,
    output logic              fwd_boot_o,
    output logic [ADDR_W-1:0] fwd_addr_o,
    output logic              fwd_we_o,
    output logic [DATA_W-1:0] fwd_wdata_o,
    output logic [GPIO_W-1:0] gpio_o,
    output logic [GPIO_W-1:0] gpio_t_o,
    output logic [DATA_W-1:0] dat_cfg_to_ctrl_o,
    output logic              cpu_irq_o
);

    decoded_req_t      cur_q;
    logic              cur_valid_q;
    logic              is_fwd, is_conf, is_intc;
    logic              conf_wr, intc_wr, conf_rd, intc_rd;
    logic [DATA_W-1:0] conf_rdata, intc_rdata, rd_data;

    // One access in service at a time, bursts wait in the queue
    assign pop_o = valid_i & ~cur_valid_q;

    always_ff @(posedge soc_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cur_valid_q <= 1'b0;
        end else begin
            cur_valid_q <= pop_o;
        end
    end

    always_ff @(posedge soc_clk) begin
        if (pop_o) cur_q <= head_i;
    end

    assign is_fwd  = (cur_q.region != REGION_LITE);
    assign is_conf = !is_fwd && (cur_q.slot == SLOT_CONF);
    assign is_intc = !is_fwd && (cur_q.slot == SLOT_INTC);
    assign conf_wr = cur_valid_q & is_conf & cur_q.we;
    assign intc_wr = cur_valid_q & is_intc & cur_q.we;
    assign conf_rd = cur_valid_q & is_conf & ~cur_q.we;
    assign intc_rd = cur_valid_q & is_intc & ~cur_q.we;

    always_comb begin
        rd_data = '0; // Writes and decode errors return zero
        if (conf_rd) rd_data = conf_rdata;
        else if (intc_rd) rd_data = intc_rdata;
    end

    confreg_regs u_confreg (
        .soc_clk           (soc_clk),
        .rst_n_i           (rst_n_i),
        .wr_i              (conf_wr),
        .rd_offset_i       (cur_q.offset),
        .wr_offset_i       (cur_q.offset),
        .wdata_i           (cur_q.wdata),
        .gpio_i            (gpio_i),
        .dat_ctrl_to_cfg_i (dat_ctrl_to_cfg_i),
        .rdata_o           (conf_rdata),
        .gpio_o            (gpio_o),
        .gpio_t_o          (gpio_t_o),
        .dat_cfg_to_ctrl_o (dat_cfg_to_ctrl_o)
    );

    irq_controller u_intc (
        .soc_clk     (soc_clk),
        .rst_n_i     (rst_n_i),
        .irq_i       (irq_i),
        .wr_i        (intc_wr),
        .wr_offset_i (cur_q.offset),
        .rd_offset_i (cur_q.offset),
        .wdata_i     (cur_q.wdata),
        .rdata_o     (intc_rdata),
        .cpu_irq_o   (cpu_irq_o)
    );

    always_ff @(posedge soc_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
            fwd_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= cur_valid_q & ~is_fwd;
            fwd_valid_o <= cur_valid_q & is_fwd;
        end
    end

    always_ff @(posedge soc_clk) begin
        if (cur_valid_q) begin
            rsp_rdata_o <= rd_data;
            rsp_resp_o  <= (is_conf || is_intc) ? RESP_OKAY : RESP_DECERR;
            fwd_boot_o  <= (cur_q.region == REGION_BOOT);
            fwd_addr_o  <= cur_q.addr;
            fwd_we_o    <= cur_q.we;
            fwd_wdata_o <= cur_q.wdata;
        end
    end

    a_one_outcome: assert property (
        @(posedge soc_clk) disable iff (!rst_n_i) !(rsp_valid_o && fwd_valid_o)
    ) else $error("periph_access_unit: response and forward together");

endmodule

//--- logic/soc_periph_top.sv
module soc_periph_top
    import soc_map_pkg::*;
    import soc_reg_pkg::*;
(
    input  logic              soc_clk,
    input  logic              rst_n_i,
    input  logic              req_valid_i,
    input  logic              req_we_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [DATA_W-1:0] req_wdata_i,
    output logic              busy_o,
    output logic              rsp_valid_o,
    output logic [DATA_W-1:0] rsp_rdata_o,
    output resp_e             rsp_resp_o,
    output logic              fwd_valid_o,
    output logic              fwd_boot_o,
    output logic [ADDR_W-1:0] fwd_addr_o,
    output logic              fwd_we_o,
    output logic [DATA_W-1:0] fwd_wdata_o,
    input  logic [GPIO_W-1:0] gpio_i,
    output logic [GPIO_W-1:0] gpio_o,
    output logic [GPIO_W-1:0] gpio_t_o,
    input  logic [DATA_W-1:0] dat_ctrl_to_cfg_i,
    output logic [DATA_W-1:0] dat_cfg_to_ctrl_o,
    input  logic [IRQ_W-1:0]  irq_i,
    output logic              cpu_irq_o
);

    logic         dec_valid;
    decoded_req_t dec_req;
    logic         fifo_valid;
    decoded_req_t fifo_head;
    logic         fifo_pop;

    periph_addr_decoder u_decoder (
        .req_valid_i (req_valid_i),
        .req_we_i    (req_we_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .dec_valid_o (dec_valid),
        .dec_req_o   (dec_req)
    );

    request_fifo u_fifo (
        .soc_clk     (soc_clk),
        .rst_n_i     (rst_n_i),
        .push_i      (dec_valid),
        .push_data_i (dec_req),
        .pop_i       (fifo_pop),
        .valid_o     (fifo_valid),
        .head_o      (fifo_head),
        .busy_o      (busy_o)
    );

    periph_access_unit u_access (
        .soc_clk           (soc_clk),
        .rst_n_i           (rst_n_i),
        .valid_i           (fifo_valid),
        .head_i            (fifo_head),
        .gpio_i            (gpio_i),
        .dat_ctrl_to_cfg_i (dat_ctrl_to_cfg_i),
        .irq_i             (irq_i),
        .pop_o             (fifo_pop),
        .rsp_valid_o       (rsp_valid_o),
        .rsp_rdata_o       (rsp_rdata_o),
        .rsp_resp_o        (rsp_resp_o),
        .fwd_valid_o       (fwd_valid_o),
        .fwd_boot_o        (fwd_boot_o),
        .fwd_addr_o        (fwd_addr_o),
        .fwd_we_o          (fwd_we_o),
        .fwd_wdata_o       (fwd_wdata_o),
        .gpio_o            (gpio_o),
        .gpio_t_o          (gpio_t_o),
        .dat_cfg_to_ctrl_o (dat_cfg_to_ctrl_o),
        .cpu_irq_o         (cpu_irq_o)
    );

endmodule

//--- bench/tb_clock_gen.sv
module tb_clock_gen (
    output logic soc_clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 4;

    initial begin
        soc_clk_o = 1'b0;
        forever #(HALF_PERIOD) soc_clk_o = ~soc_clk_o;
    end

    // Release away from the rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge soc_clk_o);
        @(negedge soc_clk_o);
        rst_n_o = 1'b1;
    end

endmodule

//--- bench/soc_periph_tb.sv
module soc_periph_tb
    import soc_map_pkg::*;
    import soc_reg_pkg::*;
();

    localparam int ROUTE_N     = 40;
    localparam int CONF_N      = 17;
    localparam int IRQ_N       = 8;
    localparam int BURST_N     = 24;
    localparam int TOTAL_REQ   = ROUTE_N + CONF_N + IRQ_N + BURST_N;
    localparam int CYCLE_LIMIT = TOTAL_REQ * 8 + 100;
    localparam logic [ADDR_W-1:0] CONF_BASE = 32'h1fe4_0000;
    localparam logic [ADDR_W-1:0] INTC_BASE = 32'h1fe6_0000;

    typedef struct packed {
        logic              fwd;
        logic              boot;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] rdata;
        resp_e             resp;
    } outcome_t;

    logic              soc_clk, rst_n;
    logic              req_valid, req_we;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic              busy, rsp_valid, fwd_valid, fwd_boot, fwd_we, cpu_irq;
    logic [DATA_W-1:0] rsp_rdata, fwd_wdata, ctrl2cfg, cfg2ctrl;
    logic [ADDR_W-1:0] fwd_addr;
    resp_e             rsp_resp;
    logic [GPIO_W-1:0] gpio_in, gpio_out, gpio_oe;
    logic [IRQ_W-1:0]  irq;

    // Expected outcomes in request order
    outcome_t   exp_mem [256];
    outcome_t   exp_head;
    logic [7:0] exp_wr_idx = 8'd0;
    logic [7:0] exp_rd_idx = 8'd0;

    logic [DATA_W-1:0] m_scratch0, m_scratch1, m_cfg2ctrl;
    logic [GPIO_W-1:0] m_gpio_out, m_gpio_oe;
    logic [IRQ_W-1:0]  m_mask;
    logic              m_pulse, exp_irq;

    int         err_cnt       = 0;
    int         outcomes_seen = 0;
    int         cycle_cnt     = 0;
    logic       burst_on      = 1'b0;
    logic       busy_seen     = 1'b0;
    logic [3:0] chk_req; // Reset, pins, irq, burst
    integer     seed;

    assign exp_head = exp_mem[exp_rd_idx];
    assign exp_irq  = |({irq[IRQ_W-1:1], m_pulse} & m_mask);

    tb_clock_gen u_clk (.soc_clk_o(soc_clk), .rst_n_o(rst_n));

    soc_periph_top u_dut (
        .soc_clk (soc_clk), .rst_n_i (rst_n),
        .req_valid_i (req_valid), .req_we_i (req_we),
        .req_addr_i (req_addr), .req_wdata_i (req_wdata),
        .busy_o (busy), .rsp_valid_o (rsp_valid),
        .rsp_rdata_o (rsp_rdata), .rsp_resp_o (rsp_resp),
        .fwd_valid_o (fwd_valid), .fwd_boot_o (fwd_boot), .fwd_addr_o (fwd_addr),
        .fwd_we_o (fwd_we), .fwd_wdata_o (fwd_wdata),
        .gpio_i (gpio_in), .gpio_o (gpio_out), .gpio_t_o (gpio_oe),
        .dat_ctrl_to_cfg_i (ctrl2cfg), .dat_cfg_to_ctrl_o (cfg2ctrl),
        .irq_i (irq), .cpu_irq_o (cpu_irq)
    );

    always @(posedge soc_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (busy && burst_on) busy_seen <= 1'b1;
        if (rsp_valid || fwd_valid) begin // Strobe lasts one cycle
            exp_rd_idx    <= exp_rd_idx + 8'd1;
            outcomes_seen <= outcomes_seen + 1;
        end
    end

    // Outputs change on the rising edge, so check on the falling one
    a_no_stray: assert property (@(negedge soc_clk) disable iff (!rst_n)
        (rsp_valid || fwd_valid) |-> (exp_rd_idx != exp_wr_idx))
    else begin
        $display("Error at %0t: outcome strobe with no request outstanding", $time);
        err_cnt++;
    end

    a_fwd_kind: assert property (@(negedge soc_clk) disable iff (!rst_n)
        fwd_valid |-> exp_head.fwd)
    else begin
        $display("MISMATCH %0t: forward for addr %h, response expected", $time, fwd_addr);
        err_cnt++;
    end

    a_rsp_kind: assert property (@(negedge soc_clk) disable iff (!rst_n)
        rsp_valid |-> !exp_head.fwd)
    else begin
        $display("MISMATCH %0t: response for addr %h, forward expected", $time, exp_head.addr);
        err_cnt++;
    end

    a_fwd_fields: assert property (@(negedge soc_clk) disable iff (!rst_n)
        (fwd_valid && exp_head.fwd) |-> (fwd_boot == exp_head.boot &&
        fwd_addr == exp_head.addr && fwd_we == exp_head.we && fwd_wdata == exp_head.wdata))
    else begin
        $display("MISMATCH %0t: forward got boot %0b addr %h we %0b data %h, expected %0b %h %0b %h",
                 $time, fwd_boot, fwd_addr, fwd_we, fwd_wdata,
                 exp_head.boot, exp_head.addr, exp_head.we, exp_head.wdata);
        err_cnt++;
    end

    a_rsp_fields: assert property (@(negedge soc_clk) disable iff (!rst_n)
        (rsp_valid && !exp_head.fwd) |->
        (rsp_resp == exp_head.resp && rsp_rdata == exp_head.rdata))
    else begin
        $display("MISMATCH %0t: addr %h response %0d data %h, expected %0d %h", $time,
                 exp_head.addr, rsp_resp, rsp_rdata, exp_head.resp, exp_head.rdata);
        err_cnt++;
    end

    a_reset_low: assert property (@(negedge soc_clk) disable iff (!rst_n)
        chk_req[0] |-> (!busy && !rsp_valid && !fwd_valid && !cpu_irq &&
        gpio_out == '0 && gpio_oe == '0 && cfg2ctrl == '0))
    else begin
        $display("MISMATCH %0t: outputs not low after reset", $time);
        err_cnt++;
    end

    a_cfg_pins: assert property (@(negedge soc_clk) disable iff (!rst_n)
        chk_req[1] |-> (gpio_out == m_gpio_out && gpio_oe == m_gpio_oe && cfg2ctrl == m_cfg2ctrl))
    else begin
        $display("MISMATCH %0t: pins gpio %h oe %h ctrl %h, expected %h %h %h", $time,
                 gpio_out, gpio_oe, cfg2ctrl, m_gpio_out, m_gpio_oe, m_cfg2ctrl);
        err_cnt++;
    end

    a_irq_out: assert property (@(negedge soc_clk) disable iff (!rst_n)
        chk_req[2] |-> (cpu_irq == exp_irq))
    else begin
        $display("MISMATCH %0t: cpu_irq_o is %0b, expected %0b", $time, cpu_irq, exp_irq);
        err_cnt++;
    end

    a_busy_seen: assert property (@(negedge soc_clk) disable iff (!rst_n)
        chk_req[3] |-> busy_seen)
    else begin
        $display("Error at %0t: busy_o never went high during the burst", $time);
        err_cnt++;
    end

    function automatic logic [1:0] classify_region(input logic [ADDR_W-1:0] addr);
        if (addr[31:28] == 4'h0) return 2'd0;
        if (addr[31:20] == 12'h1c0 || addr[31:16] == 16'h1d00) return 2'd1;
        return 2'd2;
    endfunction

    // Register model, updated in request order
    task automatic model_access(input logic we, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] wdata, output outcome_t o);
        logic [1:0]           region;
        logic [SLOT_W-1:0]    slot;
        logic [REG_OFF_W-1:0] off;
        region  = classify_region(addr);
        slot    = addr[19:16];
        off     = addr[15:0];
        o       = '0;
        o.we    = we;
        o.addr  = addr;
        o.wdata = wdata;
        o.resp  = RESP_OKAY;
        if (region != 2'd2) begin
            o.fwd  = 1'b1;
            o.boot = (region == 2'd1);
        end else if (slot == SLOT_CONF && we) begin
            case (off)
                CONF_SCRATCH0:    m_scratch0 = wdata;
                CONF_SCRATCH1:    m_scratch1 = wdata;
                CONF_CFG_TO_CTRL: m_cfg2ctrl = wdata;
                CONF_GPIO_OUT:    m_gpio_out = wdata[GPIO_W-1:0];
                CONF_GPIO_OE:     m_gpio_oe  = wdata[GPIO_W-1:0];
                default: ;
            endcase
        end else if (slot == SLOT_CONF) begin
            case (off)
                CONF_SCRATCH0:    o.rdata = m_scratch0;
                CONF_SCRATCH1:    o.rdata = m_scratch1;
                CONF_CFG_TO_CTRL: o.rdata = m_cfg2ctrl;
                CONF_CTRL_TO_CFG: o.rdata = ctrl2cfg;
                CONF_GPIO_OUT:    o.rdata = {24'h0, m_gpio_out};
                CONF_GPIO_OE:     o.rdata = {24'h0, m_gpio_oe};
                CONF_GPIO_IN:     o.rdata = {24'h0, gpio_in};
                default: ;
            endcase
        end else if (slot == SLOT_INTC && we) begin
            if (off == INTC_MASK) m_mask = wdata[IRQ_W-1:0];
            if (off == INTC_ACK && wdata[0]) m_pulse = 1'b0;
        end else if (slot == SLOT_INTC) begin
            if (off == INTC_STATUS) o.rdata = {24'h0, irq[IRQ_W-1:1], m_pulse};
            if (off == INTC_MASK) o.rdata = {24'h0, m_mask};
        end else begin
            o.resp = RESP_DECERR;
        end
    endtask

    task automatic send(input logic we, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] wdata);
        outcome_t o;
        while (busy) @(negedge soc_clk);
        model_access(we, addr, wdata, o);
        exp_mem[exp_wr_idx] = o;
        exp_wr_idx = exp_wr_idx + 8'd1;
        req_valid  = 1'b1;
        req_we     = we;
        req_addr   = addr;
        req_wdata  = wdata;
        @(negedge soc_clk);
        req_valid  = 1'b0;
    endtask

    // Mix that reaches every region and slot kind
    task automatic random_access();
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] r;
        logic [2:0]  kind;
        a    = $random(seed);
        d    = $random(seed);
        r    = $random(seed);
        kind = r[2:0];
        case (kind)
            3'd0: a = {4'h0, a[27:0]};
            3'd1: a = {12'h1c0, a[19:0]};
            3'd2: a = {16'h1d00, a[15:0]};
            3'd3: a = {CONF_BASE[31:16], 11'h0, a[2:0], 2'b00};
            3'd4: a = {INTC_BASE[31:16], 12'h0, a[1:0], 2'b00};
            3'd5: a = {12'h1fe, a[19:0]};
            default: ;
        endcase
        send(r[3], a, d);
    endtask

    task automatic wait_outcomes();
        while (exp_rd_idx != exp_wr_idx) @(negedge soc_clk);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge soc_clk);
    endtask

    task automatic request_check(input int bit_idx);
        @(posedge soc_clk);
        chk_req <= 4'b1 << bit_idx;
        @(posedge soc_clk);
        chk_req <= 4'b0;
        @(negedge soc_clk);
    endtask

    task automatic report_test(input string name, input int base);
        $display("[%0t] test %s finished with %0d errors", $time, name, err_cnt - base);
    endtask

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) @(posedge soc_clk);
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int base;
        seed       = 32'hd1b5;
        req_valid  = 1'b0;
        req_we     = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        gpio_in    = '0;
        ctrl2cfg   = '0;
        irq        = '0;
        chk_req    = 4'b0;
        m_scratch0 = '0;
        m_scratch1 = '0;
        m_cfg2ctrl = '0;
        m_gpio_out = '0;
        m_gpio_oe  = '0;
        m_mask     = '0;
        m_pulse    = 1'b0;
        @(posedge rst_n);
        @(negedge soc_clk);

        base = err_cnt;
        request_check(0);
        report_test("reset", base);

        base = err_cnt;
        for (int i = 0; i < ROUTE_N; i++) begin
            random_access();
            wait_outcomes();
        end
        report_test("routing", base);

        base     = err_cnt;
        gpio_in  = 8'ha5;
        ctrl2cfg = 32'h0bad_f00d;
        send(1'b1, {CONF_BASE[31:16], CONF_SCRATCH0}, 32'h1234_5678);
        send(1'b1, {CONF_BASE[31:16], CONF_SCRATCH1}, 32'h8765_4321);
        send(1'b1, {CONF_BASE[31:16], CONF_CFG_TO_CTRL}, 32'hcafe_0001);
        send(1'b1, {CONF_BASE[31:16], CONF_CTRL_TO_CFG}, 32'hffff_ffff); // Read only
        send(1'b1, {CONF_BASE[31:16], CONF_GPIO_OUT}, 32'h0000_003c);
        send(1'b1, {CONF_BASE[31:16], CONF_GPIO_OE}, 32'hffff_ff0f);
        for (int i = 0; i < 9; i++) send(1'b0, CONF_BASE + 32'(4 * i), 32'h0);
        wait_outcomes();
        request_check(1);
        gpio_in  = 8'h5a;
        ctrl2cfg = 32'h1357_9bdf;
        send(1'b0, {CONF_BASE[31:16], CONF_GPIO_IN}, 32'h0);
        send(1'b0, {CONF_BASE[31:16], CONF_CTRL_TO_CFG}, 32'h0);
        wait_outcomes();
        report_test("confreg", base);

        base = err_cnt;
        send(1'b1, {INTC_BASE[31:16], INTC_MASK}, 32'h0000_00fe);
        wait_outcomes();
        idle_cycles(2);
        request_check(2);
        irq = 8'h10; // Level source
        idle_cycles(2);
        request_check(2);
        send(1'b0, {INTC_BASE[31:16], INTC_STATUS}, 32'h0);
        send(1'b1, {INTC_BASE[31:16], INTC_MASK}, 32'h0000_0001);
        send(1'b0, {INTC_BASE[31:16], INTC_MASK}, 32'h0);
        wait_outcomes();
        idle_cycles(2);
        request_check(2);
        irq                = 8'h00;
        irq[IRQ_PULSE_BIT] = 1'b1;
        m_pulse            = 1'b1;
        @(negedge soc_clk);
        irq[IRQ_PULSE_BIT] = 1'b0;
        idle_cycles(2);
        send(1'b0, {INTC_BASE[31:16], INTC_STATUS}, 32'h0);
        wait_outcomes();
        request_check(2);
        idle_cycles(6); // Still pending long after the pulse
        send(1'b0, {INTC_BASE[31:16], INTC_STATUS}, 32'h0);
        send(1'b1, {INTC_BASE[31:16], INTC_ACK}, 32'h0000_0001);
        wait_outcomes();
        idle_cycles(2);
        request_check(2);
        send(1'b0, {INTC_BASE[31:16], INTC_STATUS}, 32'h0);
        wait_outcomes();
        report_test("irq", base);

        base     = err_cnt;
        burst_on = 1'b1;
        for (int i = 0; i < BURST_N; i++) random_access();
        wait_outcomes();
        request_check(3);
        report_test("burst", base);

        $display("Summary: %0d requests, %0d outcomes, %0d errors",
                 TOTAL_REQ, outcomes_seen, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- files.f
logic/soc_reg_pkg.sv
logic/soc_map_pkg.sv
logic/periph_addr_decoder.sv
logic/request_fifo.sv
logic/confreg_regs.sv
logic/irq_controller.sv
logic/periph_access_unit.sv
logic/soc_periph_top.sv
bench/tb_clock_gen.sv
bench/soc_periph_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := soc_periph_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
